// File: all.f
+incdir+include
src/eeprom_pkg.sv
src/byte_if.sv
src/i2c_link.sv
src/eeprom_ctrl.sv
src/eeprom_mem.sv
src/eeprom_top.sv
sim/eeprom_chk.sv
sim/eeprom_tb.sv

// File: Bender.yml
package:
  name: eeprom_slave

sources:
  - include_dirs:
      - include
    files:
      - src/eeprom_pkg.sv
      - src/byte_if.sv
      - src/i2c_link.sv
      - src/eeprom_ctrl.sv
      - src/eeprom_mem.sv
      - src/eeprom_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/eeprom_chk.sv
      - sim/eeprom_tb.sv

// File: sim/eeprom_tb.sv
`timescale 1ns/1ns
`include "eeprom_params.svh"

module eeprom_tb;
    logic sda;
    logic rst_n;
    logic scl;
    logic sdio_drv;     // master side, low pulls the line.
    logic sdio_oe;
    logic sdio_line;

    logic [7:0]        model_mem [bit [`EE_AW-1:0]];
    logic [`EE_AW-1:0] model_addr;
    int                checks;
    int                errors;
    int                checks_at_open;
    int                errors_at_open;

    // open drain, either side pulls low.
    assign sdio_line = (sdio_oe === 1'b1) ? 1'b0 : sdio_drv;

    eeprom_top DUT (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdio_in (sdio_line),
        .sdio_oe (sdio_oe)
    );

    always #50 sda = ~sda;

    task automatic check(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    function automatic logic [`EE_AW-1:0] rand_addr();
        logic [31:0] r;
        r = $urandom;
        return r[`EE_AW-1:0];
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    // 2047 wraps to 0.
    function automatic logic [`EE_AW-1:0] step_addr(input logic [`EE_AW-1:0] a);
        if (a == `EE_AW'(`EE_DEPTH - 1))
            return '0;
        return a + 1'b1;
    endfunction

    function automatic logic [7:0] model_byte(input logic [`EE_AW-1:0] a);
        if (model_mem.exists(a))
            return model_mem[a];
        return 8'hxx;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sda);
    endtask

    task automatic wait_line_free();
        int n;
        n = 0;
        while (sdio_oe && n < 64)
        begin
            @(posedge sda);
            n++;
        end
        if (sdio_oe)
        begin
            $display("ERROR: timeout, the DUT kept pulling sdio low");
            $display("Simulation failed");
            $finish;
        end
    endtask

    // one scl period, 8 cycles low then 8 high.
    task automatic clock_bit(input logic bit_out, output logic bit_in);
        wait_cycles(4);
        sdio_drv <= bit_out;
        wait_cycles(4);
        scl <= 1'b1;
        wait_cycles(4);
        bit_in = sdio_line;     // mid high phase.
        wait_cycles(4);
        scl <= 1'b0;
    endtask

    task automatic bus_start();
        wait_line_free();
        wait_cycles(4);
        sdio_drv <= 1'b1;
        wait_cycles(4);
        scl <= 1'b1;
        wait_cycles(8);
        sdio_drv <= 1'b0;
        wait_cycles(8);
        scl <= 1'b0;
    endtask

    task automatic bus_stop();
        wait_line_free();
        wait_cycles(4);
        sdio_drv <= 1'b0;
        wait_cycles(4);
        scl <= 1'b1;
        wait_cycles(8);
        sdio_drv <= 1'b1;
        wait_cycles(8);
    endtask

    task automatic send_byte(input logic [7:0] data, output logic ack);
        logic unused;
        for (int i = 7; i >= 0; i--)
            clock_bit(data[i], unused);
        clock_bit(1'b1, ack);   // low means acked.
    endtask

    task automatic recv_byte(input logic nack, output logic [7:0] data);
        logic b;
        for (int i = 0; i < 8; i++)
        begin
            clock_bit(1'b1, b);
            data = {data[6:0], b};
        end
        clock_bit(nack, b);
    endtask

    // cut_bits > 0 ends the transfer with a stop inside one more byte.
    task automatic write_bytes(input string name, input logic [`EE_AW-1:0] addr,
                               input logic [7:0] data [$], input int cut_bits);
        logic       ack;
        logic       unused;
        logic [7:0] junk;
        bus_start();
        send_byte({`EE_DEV_CODE, addr[10:8], 1'b0}, ack);
        check({name, " control ack"}, 8'h00, {7'd0, ack});
        send_byte(addr[7:0], ack);
        check({name, " address ack"}, 8'h00, {7'd0, ack});
        model_addr = addr;
        foreach (data[i])
        begin
            send_byte(data[i], ack);
            check({name, " data ack"}, 8'h00, {7'd0, ack});
            model_mem[model_addr] = data[i];
            model_addr = step_addr(model_addr);
        end
        junk = rand_byte();
        for (int i = 0; i < cut_bits; i++)
            clock_bit(junk[i], unused);
        bus_stop();
    endtask

    // set_addr selects a random read, otherwise the current address is used.
    task automatic read_bytes(input string name, input logic set_addr,
                              input logic [`EE_AW-1:0] addr, input int count);
        logic       ack;
        logic [7:0] d;
        bus_start();
        if (set_addr)
        begin
            send_byte({`EE_DEV_CODE, addr[10:8], 1'b0}, ack);
            check({name, " control ack"}, 8'h00, {7'd0, ack});
            send_byte(addr[7:0], ack);
            check({name, " address ack"}, 8'h00, {7'd0, ack});
            model_addr = addr;
            bus_start();        // repeated start.
        end
        send_byte({`EE_DEV_CODE, addr[10:8], 1'b1}, ack);
        check({name, " read control ack"}, 8'h00, {7'd0, ack});
        for (int i = 0; i < count; i++)
        begin
            recv_byte(i == count - 1, d);
            check({name, " data"}, model_byte(model_addr), d);
            model_addr = step_addr(model_addr);
        end
        bus_stop();
    endtask

    // the data byte differs from the stored one, so a wrongly accepted write shows.
    task automatic send_foreign(input string name, input logic [`EE_AW-1:0] addr);
        logic       ack;
        logic [7:0] r;
        logic [3:0] dev;
        r = rand_byte();
        dev = r[3:0];
        if (dev == `EE_DEV_CODE)
            dev = ~dev;
        bus_start();
        send_byte({dev, addr[10:8], 1'b0}, ack);
        check({name, " control nack"}, 8'h01, {7'd0, ack});
        send_byte(addr[7:0], ack);
        check({name, " address nack"}, 8'h01, {7'd0, ack});
        send_byte(~model_byte(addr), ack);
        check({name, " data nack"}, 8'h01, {7'd0, ack});
        bus_stop();
    endtask

    task automatic open_test();
        checks_at_open = checks;
        errors_at_open = errors;
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - checks_at_open,
                 errors - errors_at_open);
    endtask

    initial
    begin
        logic [7:0]        data [$];
        logic [`EE_AW-1:0] picked [$];
        logic [`EE_AW-1:0] addr;
        int                len;
        int                skew;
        void'($urandom(23641));
        sda = 1'b0;
        rst_n = 1'b0;
        scl = 1'b1;
        sdio_drv = 1'b1;
        checks = 0;
        errors = 0;
        model_addr = '0;
        wait_cycles(16);
        rst_n <= 1'b1;
        wait_cycles(8);

        open_test();
        for (int i = 0; i < 8; i++)
        begin
            addr = rand_addr();
            data = {rand_byte()};
            write_bytes("single write", addr, data, 0);
            picked.push_back(addr);
        end
        foreach (picked[i])
            read_bytes("single read", 1'b1, picked[i], 1);
        report_test("single_write_read");

        open_test();
        skew = int'($urandom % 6);
        addr = `EE_AW'(`EE_DEPTH - 1 - skew);
        len = skew + 2 + int'($urandom % 4);
        data = {};
        for (int i = 0; i < len; i++)
            data.push_back(rand_byte());
        write_bytes("wrap write", addr, data, 0);
        read_bytes("wrap read", 1'b1, addr, len);
        report_test("wrap_write_read");

        open_test();
        send_foreign("foreign", picked[0]);
        read_bytes("foreign read", 1'b1, picked[0], 1);
        report_test("foreign_device");

        open_test();
        addr = rand_addr();
        len = 1 + int'($urandom % 3);
        data = {};
        for (int i = 0; i <= len; i++)
            data.push_back(rand_byte());
        write_bytes("cut prefill", addr, data, 0);
        data = {};
        for (int i = 0; i < len; i++)
            data.push_back(rand_byte());
        write_bytes("cut write", addr, data, 1 + int'($urandom % 6));
        read_bytes("cut read", 1'b1, addr, len + 1);
        report_test("stop_mid_byte");

        open_test();
        addr = rand_addr();
        data = {};
        for (int i = 0; i < 6; i++)
            data.push_back(rand_byte());
        write_bytes("resume fill", addr, data, 0);
        data = {rand_byte()};
        write_bytes("resume write", addr, data, 0);
        read_bytes("current read", 1'b0, addr, 1);
        read_bytes("resume read", 1'b0, addr, 2);
        read_bytes("read after nack", 1'b0, addr, 1);
        report_test("current_address");

        $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 DUT.u_chk.fails);
        if (errors == 0 && DUT.u_chk.fails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim/eeprom_chk.sv
`timescale 1ns/1ns

module eeprom_chk
(
    input logic sda,
    input logic rst_n,
    input logic sdio_oe,
    input logic rx_valid,
    input logic tx_next,
    input logic mem_we
);
    int unsigned fails = 0;     // failed assertions so far.

    oe_after_reset: assert property (@(posedge sda) !rst_n |=> !sdio_oe)
    else
    begin
        $error("sdio_oe high in the cycle after reset");
        fails++;
    end

    rx_single: assert property (@(posedge sda) disable iff (!rst_n) rx_valid |=> !rx_valid)
    else
    begin
        $error("rx_valid high for two cycles");
        fails++;
    end

    tx_single: assert property (@(posedge sda) disable iff (!rst_n) tx_next |=> !tx_next)
    else
    begin
        $error("tx_next high for two cycles");
        fails++;
    end

    // a write lands one cycle after its byte.
    we_after_rx: assert property (@(posedge sda) disable iff (!rst_n) mem_we |-> $past(rx_valid))
    else
    begin
        $error("mem_we without rx_valid one cycle earlier");
        fails++;
    end

endmodule

bind eeprom_top eeprom_chk u_chk (
    .sda      (sda),
    .rst_n    (rst_n),
    .sdio_oe  (sdio_oe),
    .rx_valid (bus.rx_valid),
    .tx_next  (bus.tx_next),
    .mem_we   (mem_we)
);

// File: src/eeprom_top.sv
`timescale 1ns/1ns
`include "eeprom_params.svh"

module eeprom_top
(
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic sdio_in,
    output logic sdio_oe       // high pulls the line low.
);
    logic              mem_we;
    logic [`EE_AW-1:0] mem_addr;
    logic [7:0]        mem_wdata;
    logic [7:0]        mem_rdata;

    byte_if bus ();

    i2c_link u_link (
        .sda     (sda),
        .rst_n   (rst_n),
        .scl     (scl),
        .sdio_in (sdio_in),
        .sdio_oe (sdio_oe),
        .bus     (bus.link)
    );

    eeprom_ctrl u_ctrl (
        .sda       (sda),
        .rst_n     (rst_n),
        .bus       (bus.ctrl),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    eeprom_mem u_mem (
        .sda   (sda),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: src/eeprom_mem.sv
`timescale 1ns/1ns
`include "eeprom_params.svh"

module eeprom_mem
(
    input  logic              sda,
    input  logic              we,
    input  logic [`EE_AW-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);
    logic [7:0] mem [`EE_DEPTH];

    always_ff @(posedge sda)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];     // old data on a same-cycle write.
    end

endmodule

// File: src/eeprom_ctrl.sv
`timescale 1ns/1ns
`include "eeprom_params.svh"

module eeprom_ctrl import eeprom_pkg::*;
(
    input  logic              sda,
    input  logic              rst_n,
    byte_if.ctrl              bus,
    output logic              mem_we,
    output logic [`EE_AW-1:0] mem_addr,
    output logic [7:0]        mem_wdata,
    input  logic [7:0]        mem_rdata
);
    ctrl_state_t state;
    logic [2:0]  blk;
    logic        dev_ok;
    logic        rd_start;
    logic        rd_fetch;

    assign dev_ok   = (bus.rx_byte.ctrl.dev == `EE_DEV_CODE);
    assign rd_start = bus.rx_valid && bus.rx_first && dev_ok && bus.rx_byte.ctrl.rw;
    assign rd_fetch = rd_start || bus.tx_next;     // latch a byte, then step past it.

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state       <= st_idle;
            bus.ack_en  <= 1'b0;
            bus.tx_mode <= 1'b0;
            mem_we      <= 1'b0;
            mem_addr    <= '0;
        end
        else
        begin
            mem_we <= 1'b0;
            if (mem_we || rd_fetch)
                mem_addr <= mem_addr + 1'b1;    // wraps at the top.
            if (bus.bus_stop)
            begin
                state       <= st_idle;
                bus.ack_en  <= 1'b0;
                bus.tx_mode <= 1'b0;
            end
            else if (bus.rx_valid)
            begin
                if (bus.rx_first)
                begin
                    if (!dev_ok)
                    begin
                        state       <= st_ignore;
                        bus.ack_en  <= 1'b0;
                        bus.tx_mode <= 1'b0;
                    end
                    else if (bus.rx_byte.ctrl.rw)
                    begin
                        state       <= st_read_data;
                        bus.ack_en  <= 1'b1;
                        bus.tx_mode <= 1'b1;
                    end
                    else
                    begin
                        state       <= st_get_addr;
                        bus.ack_en  <= 1'b1;
                        bus.tx_mode <= 1'b0;
                    end
                end
                else
                begin
                    case (state)
                        st_get_addr:
                        begin
                            mem_addr <= {blk, bus.rx_byte.data};
                            state    <= st_write_data;
                        end
                        st_write_data:
                            mem_we <= 1'b1;
                        default:
                        begin
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (bus.rx_valid && bus.rx_first)
            blk <= bus.rx_byte.ctrl.block;
        if (bus.rx_valid)
            mem_wdata <= bus.rx_byte.data;
        if (rd_fetch)
            bus.tx_data <= mem_rdata;
    end

endmodule

// File: src/i2c_link.sv
`timescale 1ns/1ns

module i2c_link
(
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic sdio_in,
    output logic sdio_oe,
    byte_if.link bus
);
    localparam logic [2:0] ph_idle   = 3'd0;
    localparam logic [2:0] ph_rx     = 3'd1;
    localparam logic [2:0] ph_rx_ack = 3'd2;
    localparam logic [2:0] ph_tx     = 3'd3;
    localparam logic [2:0] ph_tx_ack = 3'd4;

    logic       scl_meta, scl_s, scl_d;
    logic       sdio_meta, sdio_s, sdio_d;
    logic       scl_rise, scl_fall;
    logic       start_cond, stop_cond;
    logic       rx_shift, tx_shift, tx_load;
    logic [2:0] phase;
    logic [3:0] bit_cnt;
    logic       first;
    logic [7:0] shift;

    assign scl_rise   = scl_s & ~scl_d;
    assign scl_fall   = ~scl_s & scl_d;
    assign start_cond = scl_s & scl_d & sdio_d & ~sdio_s;   // sdio falls, scl high.
    assign stop_cond  = scl_s & scl_d & ~sdio_d & sdio_s;   // sdio rises, scl high.

    assign rx_shift = (phase == ph_rx) && scl_rise && (bit_cnt != 4'd8);
    assign tx_shift = (phase == ph_tx) && scl_fall && (bit_cnt != 4'd8);
    assign tx_load  = scl_fall && (((phase == ph_rx_ack) && bus.tx_mode) ||
                                   (phase == ph_tx_ack));

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_meta     <= 1'b1;
            scl_s        <= 1'b1;
            scl_d        <= 1'b1;
            sdio_meta    <= 1'b1;
            sdio_s       <= 1'b1;
            sdio_d       <= 1'b1;
            phase        <= ph_idle;
            bit_cnt      <= 4'd0;
            first        <= 1'b0;
            sdio_oe      <= 1'b0;
            bus.rx_valid <= 1'b0;
            bus.rx_first <= 1'b0;
            bus.tx_next  <= 1'b0;
            bus.bus_stop <= 1'b0;
        end
        else
        begin
            scl_meta     <= scl;
            scl_s        <= scl_meta;
            scl_d        <= scl_s;
            sdio_meta    <= sdio_in;
            sdio_s       <= sdio_meta;
            sdio_d       <= sdio_s;
            bus.rx_valid <= 1'b0;
            bus.tx_next  <= 1'b0;
            bus.bus_stop <= 1'b0;
            if (stop_cond)
            begin
                phase        <= ph_idle;
                sdio_oe      <= 1'b0;
                bus.bus_stop <= 1'b1;
            end
            else if (start_cond)
            begin
                phase   <= ph_rx;       // also a repeated start.
                bit_cnt <= 4'd0;
                first   <= 1'b1;
                sdio_oe <= 1'b0;
            end
            else
            begin
                case (phase)
                    ph_rx:
                    begin
                        if (rx_shift)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd7)
                            begin
                                bus.rx_valid <= 1'b1;
                                bus.rx_first <= first;
                                first        <= 1'b0;
                            end
                        end
                        else if (scl_fall && bit_cnt == 4'd8)
                        begin
                            phase   <= ph_rx_ack;
                            sdio_oe <= bus.ack_en;
                        end
                    end
                    ph_rx_ack:
                    begin
                        if (scl_fall)
                        begin
                            bit_cnt <= 4'd0;
                            if (bus.tx_mode)
                            begin
                                phase   <= ph_tx;
                                sdio_oe <= ~bus.tx_data[7];     // first read bit.
                            end
                            else
                            begin
                                phase   <= ph_rx;
                                sdio_oe <= 1'b0;
                            end
                        end
                    end
                    ph_tx:
                    begin
                        if (scl_rise)
                            bit_cnt <= bit_cnt + 4'd1;
                        else if (scl_fall)
                        begin
                            if (bit_cnt == 4'd8)
                            begin
                                phase   <= ph_tx_ack;
                                sdio_oe <= 1'b0;        // master owns the ack slot.
                            end
                            else
                                sdio_oe <= ~shift[6];
                        end
                    end
                    ph_tx_ack:
                    begin
                        if (scl_rise)
                        begin
                            if (!sdio_s)
                                bus.tx_next <= 1'b1;
                            else
                                phase <= ph_idle;       // nack ends the read.
                        end
                        else if (scl_fall)
                        begin
                            phase   <= ph_tx;
                            bit_cnt <= 4'd0;
                            sdio_oe <= ~bus.tx_data[7];
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (tx_load)
            shift <= bus.tx_data;
        else if (tx_shift)
            shift <= {shift[6:0], 1'b0};
        else if (rx_shift)
            shift <= {shift[6:0], sdio_s};
        if (rx_shift && bit_cnt == 4'd7)
            bus.rx_byte.data <= {shift[6:0], sdio_s};
    end

endmodule

// File: src/byte_if.sv
`timescale 1ns/1ns

interface byte_if import eeprom_pkg::*; ();
    logic       rx_valid;   // one pulse per received byte.
    rx_byte_t   rx_byte;
    logic       rx_first;   // first byte after a start.
    logic       tx_next;    // master acked, next read byte needed.
    logic       bus_stop;
    logic       ack_en;
    logic       tx_mode;
    logic [7:0] tx_data;

    modport link (output rx_valid, rx_byte, rx_first, tx_next, bus_stop,
                  input ack_en, tx_mode, tx_data);

    modport ctrl (input rx_valid, rx_byte, rx_first, tx_next, bus_stop,
                  output ack_en, tx_mode, tx_data);

    modport chk (input rx_valid, rx_byte, rx_first, tx_next, bus_stop,
                 input ack_en, tx_mode, tx_data);
endinterface

// File: src/eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_get_addr   = 3'd1,
        st_write_data = 3'd2,
        st_read_data  = 3'd3,
        st_ignore     = 3'd4
    } ctrl_state_t;

    // fields of the control byte, msb first on the wire.
    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] block;
        logic       rw;     // 1 selects a read.
    } ctrl_view_t;

    typedef union packed {
        logic [7:0] data;
        ctrl_view_t ctrl;
    } rx_byte_t;

endpackage

// File: include/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// 8 blocks of 256 bytes.
`define EE_DEPTH 2048

// block bits plus word address.
`define EE_AW 11

// device type code in the control byte.
`define EE_DEV_CODE 4'b1010

`endif
